//--- Bender.yml
package:
  name: avs_wrapper

sources:
  - avs_pkg.sv
  - avs_rsp_if.sv
  - fifo_queue.sv
  - avs_bank_port.sv
  - rsp_arbiter.sv
  - avs_wrapper.sv
  - target: test
    files:
      - avs_bank_model.sv
      - avs_wrapper_asserts.sv
      - tb_avs_wrapper.sv

//--- avs_bank_model.sv
`timescale 1ns/1ps

module avs_bank_model import avs_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int LATENCY    = 3
) (
    input  logic                    clk,
    input  logic [ADDR_WIDTH-1:0]   address,
    input  logic [DATA_WIDTH-1:0]   writedata,
    input  logic [DATA_WIDTH/8-1:0] byteenable,
    input  logic                    write,
    input  logic                    read,
    output logic                    waitrequest,
    output logic [DATA_WIDTH-1:0]   readdata,
    output logic                    readdatavalid
);

    logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
    logic [LATENCY-1:0]    rdv_pipe = '0;
    logic [DATA_WIDTH-1:0] rd_pipe [LATENCY] = '{default: '0};

    function automatic logic [DATA_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] a);
        logic [DATA_WIDTH-1:0] w;
        w = DATA_WIDTH'({~a, a ^ ADDR_WIDTH'(16'h5a3c)});  // unwritten word
        if (mem.exists(a)) begin
            w = mem[a];
        end
        return w;
    endfunction

    initial begin
        waitrequest = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            waitrequest = ($urandom % 4) == 0;  // stall about one cycle in four
        end
    end

    always @(posedge clk) begin : slave
        logic [DATA_WIDTH-1:0] w;
        w = word_at(address);
        if (write && !waitrequest) begin
            for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                if (byteenable[b]) begin
                    w[8*b +: 8] = writedata[8*b +: 8];
                end
            end
            mem[address] = w;
        end
        rdv_pipe   <= {rdv_pipe[LATENCY-2:0], read && !waitrequest};
        rd_pipe[0] <= w;
        for (int i = 1; i < LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign readdatavalid = rdv_pipe[LATENCY-1];
    assign readdata      = rd_pipe[LATENCY-1];

endmodule

//--- avs_bank_port.sv
`timescale 1ns/1ps

module avs_bank_port import avs_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int TAG_WIDTH  = DEF_TAG_WIDTH,
    parameter int QUEUE_SIZE = DEF_QUEUE_SIZE
) (
    input  logic                  clk,
    input  logic                  rst,

    // request from the wrapper
    input  logic                  sel,
    input  logic                  req_valid,
    input  logic                  req_rw,
    input  logic [TAG_WIDTH-1:0]  req_tag,
    output logic                  accept,

    // avalon side of this bank
    output logic                  read,
    output logic                  write,
    input  logic                  waitrequest,
    input  logic [DATA_WIDTH-1:0] readdata,
    input  logic                  readdatavalid,

    avs_rsp_if.bank               rsp
);

    localparam int CNTW = log2up(QUEUE_SIZE + 1);

    logic [CNTW-1:0]       pending;
    logic                  below_limit;
    logic                  rd_taken;
    logic                  rsp_fire;
    logic                  data_empty;
    logic [TAG_WIDTH-1:0]  tag_head;
    logic [DATA_WIDTH-1:0] data_head;

    assign below_limit = (pending < CNTW'(QUEUE_SIZE));
    assign accept      = below_limit && !waitrequest;

    // bus stays quiet while in reset
    assign read  = !rst && sel && req_valid && !req_rw && below_limit;
    assign write = !rst && sel && req_valid && req_rw && below_limit;

    assign rd_taken = read && !waitrequest;  // slave took the read
    assign rsp_fire = rsp.valid && rsp.ready;

    // outstanding reads, both issued and not yet returned upstream
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            case ({rd_taken, rsp_fire})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    fifo_queue #(
        .DATAW (TAG_WIDTH),
        .SIZE  (QUEUE_SIZE)
    ) u_tag_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (rd_taken),
        .pop      (rsp_fire),
        .data_in  (req_tag),
        .data_out (tag_head),
        .empty    ()  // tracks the data queue
    );

    fifo_queue #(
        .DATAW (DATA_WIDTH),
        .SIZE  (QUEUE_SIZE)
    ) u_data_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (readdatavalid),
        .pop      (rsp_fire),
        .data_in  (readdata),
        .data_out (data_head),
        .empty    (data_empty)
    );

    // data head pairs with the oldest tag
    assign rsp.valid = !data_empty;
    assign rsp.data  = data_head;
    assign rsp.tag   = tag_head;

endmodule

//--- avs_pkg.sv
package avs_pkg;

    // default sizes, overridden from the top level
    localparam int DEF_DATA_WIDTH  = 32;
    localparam int DEF_ADDR_WIDTH  = 16;  // word address
    localparam int DEF_BURST_WIDTH = 4;
    localparam int DEF_BANKS       = 2;
    localparam int DEF_TAG_WIDTH   = 4;
    localparam int DEF_QUEUE_SIZE  = 4;  // max outstanding reads per bank

    // ceiling log2, never below one bit
    function automatic int log2up(input int n);
        int bits;
        bits = $clog2(n);
        if (bits < 1) begin
            bits = 1;
        end
        return bits;
    endfunction

endpackage

//--- avs_rsp_if.sv
`timescale 1ns/1ps

interface avs_rsp_if import avs_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int TAG_WIDTH  = DEF_TAG_WIDTH
);

    logic                  valid;
    logic [DATA_WIDTH-1:0] data;
    logic [TAG_WIDTH-1:0]  tag;
    logic                  ready;  // from arbiter, winner only

    modport bank (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport arb (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

//--- avs_wrapper.sv
`timescale 1ns/1ps

module avs_wrapper import avs_pkg::*; #(
    parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH  = DEF_ADDR_WIDTH,
    parameter int BURST_WIDTH = DEF_BURST_WIDTH,
    parameter int BANKS       = DEF_BANKS,
    parameter int TAG_WIDTH   = DEF_TAG_WIDTH,
    parameter int QUEUE_SIZE  = DEF_QUEUE_SIZE
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // memory request
    input  logic                                  mem_req_valid,
    input  logic                                  mem_req_rw,
    input  logic [DATA_WIDTH/8-1:0]               mem_req_byteen,
    input  logic [ADDR_WIDTH-1:0]                 mem_req_addr,
    input  logic [DATA_WIDTH-1:0]                 mem_req_data,
    input  logic [TAG_WIDTH-1:0]                  mem_req_tag,
    output logic                                  mem_req_ready,

    // memory response
    output logic                                  mem_rsp_valid,
    output logic [DATA_WIDTH-1:0]                 mem_rsp_data,
    output logic [TAG_WIDTH-1:0]                  mem_rsp_tag,
    input  logic                                  mem_rsp_ready,

    // avalon banks
    output logic [BANKS-1:0][DATA_WIDTH-1:0]      avs_writedata,
    input  logic [BANKS-1:0][DATA_WIDTH-1:0]      avs_readdata,
    output logic [BANKS-1:0][ADDR_WIDTH-1:0]      avs_address,
    input  logic [BANKS-1:0]                      avs_waitrequest,
    output logic [BANKS-1:0]                      avs_write,
    output logic [BANKS-1:0]                      avs_read,
    output logic [BANKS-1:0][DATA_WIDTH/8-1:0]    avs_byteenable,
    output logic [BANKS-1:0][BURST_WIDTH-1:0]     avs_burstcount,
    input  logic [BANKS-1:0]                      avs_readdatavalid
);

    localparam int BYTEENW = DATA_WIDTH / 8;
    localparam int SELW    = log2up(BANKS);

    logic [SELW-1:0]  bank_sel;
    logic [BANKS-1:0] bank_accept;

    avs_rsp_if #(.DATA_WIDTH(DATA_WIDTH), .TAG_WIDTH(TAG_WIDTH)) rsp_if [BANKS] ();

    if (BANKS > 1) begin : g_sel
        assign bank_sel = mem_req_addr[SELW-1:0];  // low word bits interleave banks
    end else begin : g_nosel
        assign bank_sel = '0;
    end

    assign mem_req_ready = bank_accept[bank_sel];

    for (genvar i = 0; i < BANKS; i++) begin : g_bank
        assign avs_address[i]    = mem_req_addr;
        assign avs_writedata[i]  = mem_req_data;
        assign avs_byteenable[i] = BYTEENW'(mem_req_byteen);
        assign avs_burstcount[i] = BURST_WIDTH'(1);  // single beat only

        avs_bank_port #(
            .DATA_WIDTH (DATA_WIDTH),
            .TAG_WIDTH  (TAG_WIDTH),
            .QUEUE_SIZE (QUEUE_SIZE)
        ) u_bank_port (
            .clk           (clk),
            .rst           (rst),
            .sel           (bank_sel == SELW'(i)),
            .req_valid     (mem_req_valid),
            .req_rw        (mem_req_rw),
            .req_tag       (mem_req_tag),
            .accept        (bank_accept[i]),
            .read          (avs_read[i]),
            .write         (avs_write[i]),
            .waitrequest   (avs_waitrequest[i]),
            .readdata      (avs_readdata[i]),
            .readdatavalid (avs_readdatavalid[i]),
            .rsp           (rsp_if[i])
        );
    end

    rsp_arbiter #(
        .BANKS      (BANKS),
        .DATA_WIDTH (DATA_WIDTH),
        .TAG_WIDTH  (TAG_WIDTH)
    ) u_rsp_arbiter (
        .clk       (clk),
        .rst       (rst),
        .rsp       (rsp_if),
        .rsp_valid (mem_rsp_valid),
        .rsp_data  (mem_rsp_data),
        .rsp_tag   (mem_rsp_tag),
        .rsp_ready (mem_rsp_ready)
    );

endmodule

//--- avs_wrapper_asserts.sv
`timescale 1ns/1ps

module avs_wrapper_asserts import avs_pkg::*; #(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BANKS      = DEF_BANKS
) (
    input logic                  clk,
    input logic                  rst,
    input logic [ADDR_WIDTH-1:0] mem_req_addr,
    input logic                  mem_rsp_valid,
    input logic                  mem_rsp_ready,
    input logic [BANKS-1:0]      avs_read,
    input logic [BANKS-1:0]      avs_write
);

    int fail_count = 0;

    logic [BANKS-1:0] strobes;
    logic [BANKS-1:0] sel_mask;

    assign strobes  = avs_read | avs_write;
    assign sel_mask = BANKS'(1) << (mem_req_addr % BANKS);  // bank from low address bits

    a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
        (avs_read & avs_write) == '0)
    else begin
        fail_count++;
        $error("read and write strobed together on one bank");
    end

    a_sel_bank_only: assert property (@(posedge clk) disable iff (rst)
        (strobes & ~sel_mask) == '0)
    else begin
        fail_count++;
        $error("strobe on a bank the address does not select");
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid)
    else begin
        fail_count++;
        $error("mem_rsp_valid dropped before the response was taken");
    end

    a_quiet_in_reset: assert property (@(posedge clk) rst |-> strobes == '0)
    else begin
        fail_count++;
        $error("avalon strobe while rst is high");
    end

endmodule

bind avs_wrapper avs_wrapper_asserts #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BANKS      (BANKS)
) u_asserts (
    .clk           (clk),
    .rst           (rst),
    .mem_req_addr  (mem_req_addr),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_ready (mem_rsp_ready),
    .avs_read      (avs_read),
    .avs_write     (avs_write)
);

//--- fifo_queue.sv
`timescale 1ns/1ps

module fifo_queue import avs_pkg::*; #(
    parameter int DATAW = DEF_DATA_WIDTH,
    parameter int SIZE  = DEF_QUEUE_SIZE
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out,
    output logic             empty
);

    localparam int PTRW = log2up(SIZE);
    localparam int CNTW = log2up(SIZE + 1);

    logic [DATAW-1:0] mem [SIZE];
    logic [PTRW-1:0]  rd_ptr;
    logic [PTRW-1:0]  wr_ptr;
    logic [PTRW-1:0]  rd_ptr_next;
    logic [CNTW-1:0]  count;
    logic [CNTW-1:0]  count_next;
    logic             head_bypass;

    // wrap for sizes that are not a power of two
    function automatic logic [PTRW-1:0] ptr_inc(input logic [PTRW-1:0] p);
        logic [PTRW-1:0] q;
        q = (p == PTRW'(SIZE - 1)) ? '0 : p + 1'b1;
        return q;
    endfunction

    always_comb begin
        rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;
        count_next  = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // no older entry left behind the head, so the pushed word becomes it
    assign head_bypass = push && (count == CNTW'(pop));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (head_bypass) begin
            data_out <= data_in;
        end else begin
            data_out <= mem[rd_ptr_next];  // don't care once empty
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
        end else begin
            rd_ptr <= rd_ptr_next;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            count <= count_next;
            empty <= (count_next == '0);
        end
    end

endmodule

//--- list.f
avs_pkg.sv
avs_rsp_if.sv
fifo_queue.sv
avs_bank_port.sv
rsp_arbiter.sv
avs_wrapper.sv
avs_bank_model.sv
avs_wrapper_asserts.sv
tb_avs_wrapper.sv

//--- rsp_arbiter.sv
`timescale 1ns/1ps

module rsp_arbiter import avs_pkg::*; #(
    parameter int BANKS      = DEF_BANKS,
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int TAG_WIDTH  = DEF_TAG_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    avs_rsp_if.arb                rsp [BANKS],

    output logic                  rsp_valid,
    output logic [DATA_WIDTH-1:0] rsp_data,
    output logic [TAG_WIDTH-1:0]  rsp_tag,
    input  logic                  rsp_ready
);

    localparam int PTRW = log2up(BANKS);

    logic [BANKS-1:0]                 valid_vec;
    logic [BANKS-1:0][DATA_WIDTH-1:0] data_vec;
    logic [BANKS-1:0][TAG_WIDTH-1:0]  tag_vec;
    logic [PTRW-1:0]                  last_win;
    logic [PTRW-1:0]                  grant_idx;
    logic                             found;

    for (genvar i = 0; i < BANKS; i++) begin : g_bank
        assign valid_vec[i] = rsp[i].valid;
        assign data_vec[i]  = rsp[i].data;
        assign tag_vec[i]   = rsp[i].tag;
        assign rsp[i].ready = rsp_ready && found && (grant_idx == PTRW'(i));
    end

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant_idx = last_win;
        found     = 1'b0;
        for (int k = 1; k <= BANKS; k++) begin
            idx = (int'(last_win) + k) % BANKS;
            if (!found && valid_vec[idx]) begin
                found     = 1'b1;
                grant_idx = PTRW'(idx);
            end
        end
    end

    assign rsp_valid = found;
    assign rsp_data  = data_vec[grant_idx];
    assign rsp_tag   = tag_vec[grant_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            last_win <= PTRW'(BANKS - 1);  // bank 0 first
        end else if (rsp_valid && rsp_ready) begin
            last_win <= grant_idx;
        end
    end

endmodule

//--- tb_avs_wrapper.sv
`timescale 1ns/1ps

module tb_avs_wrapper import avs_pkg::*; ();

    localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
    localparam int ADDR_WIDTH  = DEF_ADDR_WIDTH;
    localparam int BURST_WIDTH = DEF_BURST_WIDTH;
    localparam int BANKS       = DEF_BANKS;
    localparam int TAG_WIDTH   = DEF_TAG_WIDTH;
    localparam int QUEUE_SIZE  = DEF_QUEUE_SIZE;
    localparam int NUM_ROWS    = 20;
    localparam int TIMEOUT     = NUM_ROWS * 40 + 200;

    typedef struct packed {
        logic                    rw;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH/8-1:0] byteen;
        logic [DATA_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
        logic [7:0]              hold;
    } row_t;

    // rw, addr, byteen, data, tag, cycles of mem_rsp_ready low after issue
    localparam row_t STIM [NUM_ROWS] = '{
        '{1'b1, 16'h0010, 4'hf, 32'h1122_3344, 4'd0, 8'd0},
        '{1'b1, 16'h0010, 4'h5, 32'haabb_ccdd, 4'd0, 8'd0},  // byte merge
        '{1'b0, 16'h0010, 4'hf, 32'h0, 4'd1, 8'd0},
        '{1'b1, 16'h0013, 4'h8, 32'hff00_0000, 4'd0, 8'd0},
        '{1'b0, 16'h0013, 4'hf, 32'h0, 4'd2, 8'd0},
        '{1'b0, 16'h0020, 4'hf, 32'h0, 4'd3, 8'd0},
        '{1'b0, 16'h0021, 4'hf, 32'h0, 4'd4, 8'd0},
        '{1'b0, 16'h0022, 4'hf, 32'h0, 4'd5, 8'd0},
        '{1'b0, 16'h0023, 4'hf, 32'h0, 4'd6, 8'd0},
        '{1'b0, 16'h0025, 4'hf, 32'h0, 4'd7, 8'd0},
        '{1'b0, 16'h0024, 4'hf, 32'h0, 4'd8, 8'd0},
        '{1'b0, 16'h0040, 4'hf, 32'h0, 4'd9, 8'd24},  // fill bank 0 while held
        '{1'b0, 16'h0042, 4'hf, 32'h0, 4'd10, 8'd0},
        '{1'b0, 16'h0044, 4'hf, 32'h0, 4'd11, 8'd0},
        '{1'b0, 16'h0046, 4'hf, 32'h0, 4'd12, 8'd0},
        '{1'b0, 16'h0048, 4'hf, 32'h0, 4'd13, 8'd0},
        '{1'b0, 16'h0049, 4'hf, 32'h0, 4'd14, 8'd0},
        '{1'b1, 16'h0049, 4'h3, 32'h0000_beef, 4'd0, 8'd3},
        '{1'b0, 16'h0049, 4'hf, 32'h0, 4'd15, 8'd0},
        '{1'b0, 16'h0048, 4'hf, 32'h0, 4'd0, 8'd0}
    };

    logic clk = 1'b0;
    logic rst;
    logic                               mem_req_valid, mem_req_rw, mem_req_ready;
    logic [DATA_WIDTH/8-1:0]            mem_req_byteen;
    logic [ADDR_WIDTH-1:0]              mem_req_addr;
    logic [DATA_WIDTH-1:0]              mem_req_data, mem_rsp_data;
    logic [TAG_WIDTH-1:0]               mem_req_tag, mem_rsp_tag;
    logic                               mem_rsp_valid, mem_rsp_ready;
    logic [BANKS-1:0][DATA_WIDTH-1:0]   avs_writedata, avs_readdata;
    logic [BANKS-1:0][ADDR_WIDTH-1:0]   avs_address;
    logic [BANKS-1:0][DATA_WIDTH/8-1:0] avs_byteenable;
    logic [BANKS-1:0][BURST_WIDTH-1:0]  avs_burstcount;
    logic [BANKS-1:0]                   avs_waitrequest, avs_write, avs_read, avs_readdatavalid;

    logic [DATA_WIDTH-1:0] ref_mem [logic [ADDR_WIDTH-1:0]];
    logic [DATA_WIDTH-1:0] exp_word [logic [TAG_WIDTH-1:0]];  // expected data per open tag
    int                    tag_bank [logic [TAG_WIDTH-1:0]];
    logic [TAG_WIDTH-1:0]  order_q [BANKS][$];
    int                    outstanding [BANKS] = '{default: 0};
    int                    reads_seen = 0;
    int                    rsps_seen = 0;
    int                    full_seen = 0;
    int                    cycles = 0;
    int                    hold_cnt = 0;

    always #10 clk = ~clk;

    avs_wrapper #(
        .DATA_WIDTH (DATA_WIDTH), .ADDR_WIDTH (ADDR_WIDTH), .BURST_WIDTH (BURST_WIDTH),
        .BANKS (BANKS), .TAG_WIDTH (TAG_WIDTH), .QUEUE_SIZE (QUEUE_SIZE)
    ) u_avs_wrapper (.*);

    for (genvar b = 0; b < BANKS; b++) begin : g_model
        avs_bank_model #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_bank (
            .clk           (clk),
            .address       (avs_address[b]),
            .writedata     (avs_writedata[b]),
            .byteenable    (avs_byteenable[b]),
            .write         (avs_write[b]),
            .read          (avs_read[b]),
            .waitrequest   (avs_waitrequest[b]),
            .readdata      (avs_readdata[b]),
            .readdatavalid (avs_readdatavalid[b])
        );
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp,
                              input logic [TAG_WIDTH-1:0] tag);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: tag %0d data %h, expected %h",
                               $time, tag, got, exp));
        end
    endtask

    task automatic check_tag(input logic [TAG_WIDTH-1:0] got, input logic [TAG_WIDTH-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: response tag %0d, expected %0d in bank order",
                               $time, got, exp));
        end
    endtask

    task automatic check_burst(input logic [BURST_WIDTH-1:0] got,
                               input logic [BURST_WIDTH-1:0] exp, input int bank);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: bank %0d burstcount %0d, expected %0d",
                               $time, bank, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] ref_word(input logic [ADDR_WIDTH-1:0] a);
        logic [DATA_WIDTH-1:0] w;
        w = {~a, a ^ 16'h5a3c};  // contents before any write
        if (ref_mem.exists(a)) begin
            w = ref_mem[a];
        end
        return w;
    endfunction

    always @(posedge clk) begin : monitor
        int bank;
        int rbank;
        logic [DATA_WIDTH-1:0] w;
        bank = int'(mem_req_addr % BANKS);
        if (!rst && u_avs_wrapper.u_asserts.fail_count != 0) begin
            stop_run("a bound assertion on the DUT ports failed");
        end else if (!rst) begin
            for (int k = 0; k < BANKS; k++) begin
                if (avs_read[k] || avs_write[k]) begin
                    check_burst(avs_burstcount[k], BURST_WIDTH'(1), k);  // single beat
                end
            end
            if (mem_req_valid && outstanding[bank] == QUEUE_SIZE) begin
                check_flag(mem_req_ready, 1'b0, "mem_req_ready into a full bank");
                full_seen++;
            end
            if (mem_req_valid && mem_req_ready && mem_req_rw) begin
                w = ref_word(mem_req_addr);
                for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                    if (mem_req_byteen[b]) begin
                        w[8*b +: 8] = mem_req_data[8*b +: 8];
                    end
                end
                ref_mem[mem_req_addr] = w;
            end else if (mem_req_valid && mem_req_ready) begin
                if (exp_word.exists(mem_req_tag)) begin
                    stop_run("a read tag was issued again while still outstanding");
                end else begin
                    exp_word[mem_req_tag] = ref_word(mem_req_addr);
                    tag_bank[mem_req_tag] = bank;
                    order_q[bank].push_back(mem_req_tag);
                    outstanding[bank]++;
                    reads_seen++;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                if (!exp_word.exists(mem_rsp_tag)) begin
                    stop_run("a response came back with a tag that is not outstanding");
                end else begin
                    rbank = tag_bank[mem_rsp_tag];
                    check_tag(mem_rsp_tag, order_q[rbank][0]);
                    check_data(mem_rsp_data, exp_word[mem_rsp_tag], mem_rsp_tag);
                    order_q[rbank].delete(0);
                    exp_word.delete(mem_rsp_tag);
                    tag_bank.delete(mem_rsp_tag);
                    outstanding[rbank]--;
                    rsps_seen++;
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        mem_rsp_ready = (hold_cnt == 0);  // back-pressure window
        if (hold_cnt > 0) begin
            hold_cnt--;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_run($sformatf("timeout after %0d cycles, read responses missing (%0d of %0d)",
                                   cycles, rsps_seen, reads_seen));
            end
        end
    end

    initial begin
        int n_reads;
        n_reads = 0;
        void'($urandom(32'h30dc));
        rst            = 1'b1;
        mem_req_valid  = 1'b0;
        mem_req_rw     = 1'b0;
        mem_req_byteen = '0;
        mem_req_addr   = '0;
        mem_req_data   = '0;
        mem_req_tag    = '0;
        mem_rsp_ready  = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        mem_req_valid = 1'b1;  // read presented while still in reset
        repeat (5) @(posedge clk);
        #1;
        mem_req_valid = 1'b0;
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            mem_req_valid  = 1'b1;
            mem_req_rw     = STIM[i].rw;
            mem_req_addr   = STIM[i].addr;
            mem_req_byteen = STIM[i].byteen;
            mem_req_data   = STIM[i].data;
            mem_req_tag    = STIM[i].tag;
            if (!STIM[i].rw) begin
                n_reads++;
            end
            do begin
                @(posedge clk);
            end while (!mem_req_ready);
            if (int'(STIM[i].hold) > hold_cnt) begin
                hold_cnt = STIM[i].hold;
            end
            #1;
        end
        mem_req_valid = 1'b0;
        wait (rsps_seen == reads_seen);
        repeat (20) @(posedge clk);  // room for any stray response
        #1;
        if (reads_seen == n_reads && rsps_seen == n_reads && full_seen > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_run($sformatf("%0d reads in table, %0d issued, %0d returned, full bank seen %0d",
                               n_reads, reads_seen, rsps_seen, full_seen));
        end
    end

endmodule
